//--- rtl/mipsPkg.sv
package mipsPkg;

    localparam int DATA_W = 32;                   // Word width
    localparam int REG_AW = 5;                    // Register index width

    // Primary opcodes, instr[31:26]
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_ADDI  = 6'h08;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;
    localparam logic [5:0] OP_BEQ   = 6'h04;

    // R-type function field, instr[5:0]
    localparam logic [5:0] FN_ADD = 6'h20;
    localparam logic [5:0] FN_SUB = 6'h22;
    localparam logic [5:0] FN_AND = 6'h24;
    localparam logic [5:0] FN_OR  = 6'h25;
    localparam logic [5:0] FN_SLT = 6'h2a;

    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT} aluOpT;

    typedef enum logic [1:0] {
        FWD_REG = 2'd0,                           // Value from ID/EX
        FWD_WB  = 2'd1,                           // Writeback result
        FWD_MEM = 2'd2                            // ALU result in memory stage
    } fwdT;

    ////////////////////////////////////////////////////////////////////////////
    // Pipeline latch payloads, all-zero is a bubble
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [DATA_W-1:0] instr;
        logic [DATA_W-1:0] pcPlus4;
    } ifIdT;

    typedef struct packed {
        logic              regWrite;
        logic              memToReg;
        logic              memWrite;
        logic              aluSrc;                // Immediate as operand B
        logic              regDst;                // rd, else rt
        aluOpT             aluOp;
        logic [DATA_W-1:0] rd1;
        logic [DATA_W-1:0] rd2;
        logic [DATA_W-1:0] imm;                   // Sign extended
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
    } idExT;

    typedef struct packed {
        logic              regWrite;
        logic              memToReg;
        logic              memWrite;
        logic [DATA_W-1:0] aluOut;
        logic [DATA_W-1:0] writeData;             // Store data
        logic [REG_AW-1:0] writeReg;
    } exMemT;

    typedef struct packed {
        logic              regWrite;
        logic              memToReg;
        logic [DATA_W-1:0] readData;
        logic [DATA_W-1:0] aluOut;
        logic [REG_AW-1:0] writeReg;
    } memWbT;

endpackage

//--- rtl/pipeReg.sv
`timescale 1ns/1ps

module pipeReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    en,                           // Low holds the stage
    input  logic    flush,                        // Loads a bubble
    input  payloadT d,
    output payloadT q
);

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            q <= '0;                              // Bubble out of reset
        else if (flush)
            q <= '0;
        else if (en)
            q <= d;
    end

    // Hazard logic never holds and kills the same stage in one cycle
    holdFlushA: assert property (@(posedge clk) disable iff (!arstN) !(flush && !en));

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic [mipsPkg::REG_AW-1:0]  a1,
    input  logic [mipsPkg::REG_AW-1:0]  a2,
    input  logic [mipsPkg::REG_AW-1:0]  a3,       // Write index
    input  logic                        we,
    input  logic [mipsPkg::DATA_W-1:0]  wd,
    output logic [mipsPkg::DATA_W-1:0]  rd1,
    output logic [mipsPkg::DATA_W-1:0]  rd2
);

    localparam int DEPTH = 2 ** mipsPkg::REG_AW;

    logic [mipsPkg::DATA_W-1:0] regs [DEPTH];
    logic                       wrLive;           // Write that actually lands

    assign wrLive = we && (a3 != '0);             // r0 stays zero

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            regs <= '{default: '0};
        else if (wrLive)
            regs[a3] <= wd;
    end

    // Same-cycle write bypass, covers WB to ID
    assign rd1 = (wrLive && a3 == a1) ? wd : regs[a1];
    assign rd2 = (wrLive && a3 == a2) ? wd : regs[a2];

endmodule

//--- rtl/controlUnit.sv
`timescale 1ns/1ps

module controlUnit (
    input  logic [5:0]     op,
    input  logic [5:0]     funct,
    output logic           regWrite,
    output logic           memToReg,
    output logic           memWrite,
    output logic           aluSrc,
    output logic           regDst,
    output logic           branch,
    output mipsPkg::aluOpT aluOp
);

    always_comb
    begin
        regWrite = 1'b0;                          // Defaults give a no-op
        memToReg = 1'b0;
        memWrite = 1'b0;
        aluSrc   = 1'b0;
        regDst   = 1'b0;
        branch   = 1'b0;
        aluOp    = mipsPkg::ALU_ADD;
        case (op)
            mipsPkg::OP_RTYPE:
            begin
                regDst = 1'b1;
                case (funct)
                    mipsPkg::FN_ADD: aluOp = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUB: aluOp = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND: aluOp = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:  aluOp = mipsPkg::ALU_OR;
                    mipsPkg::FN_SLT: aluOp = mipsPkg::ALU_SLT;
                    default:         regDst = 1'b0;   // Unknown funct
                endcase
                regWrite = regDst;                // Only the five known functs
            end
            mipsPkg::OP_ADDI:
            begin
                regWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            mipsPkg::OP_LW:
            begin
                regWrite = 1'b1;
                memToReg = 1'b1;
                aluSrc   = 1'b1;                  // base + offset
            end
            mipsPkg::OP_SW:
            begin
                memWrite = 1'b1;
                aluSrc   = 1'b1;
            end
            mipsPkg::OP_BEQ:
                branch = 1'b1;                    // Resolved in decode
            default:
                branch = 1'b0;
        endcase
    end

endmodule

//--- rtl/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic [mipsPkg::REG_AW-1:0] rsD,
    input  logic [mipsPkg::REG_AW-1:0] rtD,
    input  logic [mipsPkg::REG_AW-1:0] rsE,
    input  logic [mipsPkg::REG_AW-1:0] rtE,
    input  logic [mipsPkg::REG_AW-1:0] writeRegE,
    input  logic [mipsPkg::REG_AW-1:0] writeRegM,
    input  logic [mipsPkg::REG_AW-1:0] writeRegW,
    input  logic                       regWriteE,
    input  logic                       regWriteM,
    input  logic                       regWriteW,
    input  logic                       memToRegE,
    input  logic                       memToRegM,
    input  logic                       branchD,
    output logic                       stall,
    output logic                       flushE,
    output logic                       forwardAD,
    output logic                       forwardBD,
    output mipsPkg::fwdT               forwardAE,
    output mipsPkg::fwdT               forwardBE
);

    logic lwStall;
    logic branchStall;
    logic hitE;                                   // Branch source written in EX
    logic hitM;                                   // Branch source loaded in MEM

    // Execute operands, youngest producer wins
    always_comb
    begin
        forwardAE = mipsPkg::FWD_REG;
        forwardBE = mipsPkg::FWD_REG;
        if (rsE != '0 && regWriteM && rsE == writeRegM)
            forwardAE = mipsPkg::FWD_MEM;
        else if (rsE != '0 && regWriteW && rsE == writeRegW)
            forwardAE = mipsPkg::FWD_WB;
        if (rtE != '0 && regWriteM && rtE == writeRegM)
            forwardBE = mipsPkg::FWD_MEM;
        else if (rtE != '0 && regWriteW && rtE == writeRegW)
            forwardBE = mipsPkg::FWD_WB;
    end

    // Branch compare only taps the MEM ALU result
    assign forwardAD = (rsD != '0) && regWriteM && (rsD == writeRegM);
    assign forwardBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

    assign lwStall = memToRegE && (rtE != '0) && (rtE == rsD || rtE == rtD);

    assign hitE = regWriteE && (writeRegE != '0) && (writeRegE == rsD || writeRegE == rtD);
    assign hitM = memToRegM && (writeRegM != '0) && (writeRegM == rsD || writeRegM == rtD);
    assign branchStall = branchD && (hitE || hitM);

    assign stall  = lwStall || branchStall;       // Holds PC and IF/ID
    assign flushE = stall;                        // Bubble into ID/EX

endmodule

//--- rtl/wordMem.sv
`timescale 1ns/1ps

module wordMem #(
    parameter int WORDS = 16
) (
    input  logic                       clk,
    input  logic                       we,
    input  logic [$clog2(WORDS)-1:0]   addr,      // Word index
    input  logic [mipsPkg::DATA_W-1:0] wdata,
    output logic [mipsPkg::DATA_W-1:0] rdata
);

    logic [mipsPkg::DATA_W-1:0] mem [WORDS] = '{default: '0};   // Starts cleared

    always_ff @(posedge clk)
    begin
        if (we)
            mem[addr] <= wdata;
    end

    assign rdata = mem[addr];                     // Async read

    // Non power of two depths leave holes in the index space
    addrRangeA: assert property (@(posedge clk) we |-> (addr < WORDS));

endmodule

//--- rtl/dataPath.sv
`timescale 1ns/1ps

module dataPath #(
    parameter int IMEM_WORDS = 64,
    parameter int DMEM_WORDS = 16
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          imemWe,         // Program load, reset only
    input  logic [$clog2(IMEM_WORDS)-1:0] imemAddr,
    input  logic [mipsPkg::DATA_W-1:0]    imemData,
    output logic                          wbValid,
    output logic [mipsPkg::REG_AW-1:0]    wbReg,
    output logic [mipsPkg::DATA_W-1:0]    wbData,
    output logic                          stValid,
    output logic [$clog2(DMEM_WORDS)-1:0] stAddr,
    output logic [mipsPkg::DATA_W-1:0]    stData
);

    localparam int W  = mipsPkg::DATA_W;
    localparam int IA = $clog2(IMEM_WORDS);
    localparam int DA = $clog2(DMEM_WORDS);

    logic [W-1:0]                  pcF, pcNextF, pcPlus4F, instrF;
    logic [IA-1:0]                 imemIdx;
    logic [W-1:0]                  instrD, rd1D, rd2D, immD, pcBranchD, cmpAD, cmpBD;
    logic [mipsPkg::REG_AW-1:0]    rsD, rtD, rdD;
    logic                          regWriteD, memToRegD, memWriteD, aluSrcD, regDstD;
    logic                          branchD, takenD;
    mipsPkg::aluOpT                aluOpD;
    logic                          stall, flushE, forwardAD, forwardBD;
    mipsPkg::fwdT                  forwardAE, forwardBE;
    logic [W-1:0]                  srcAE, srcBE, writeDataE, aluOutE;
    logic [mipsPkg::REG_AW-1:0]    writeRegE;
    logic [DA-1:0]                 dmemIdx;
    logic [W-1:0]                  readDataM, resultW;

    mipsPkg::ifIdT  ifIdIn,  ifIdOut;
    mipsPkg::idExT  idExIn,  idExOut;
    mipsPkg::exMemT exMemIn, exMemOut;
    mipsPkg::memWbT memWbIn, memWbOut;

    ////////////////////////////////////////////////////////////////////////////
    // Fetch
    ////////////////////////////////////////////////////////////////////////////

    assign pcPlus4F = pcF + W'(4);
    assign pcNextF  = takenD ? pcBranchD : pcPlus4F;  // Branch redirect from decode

    always_ff @(posedge clk or negedge arstN)
    begin
        if (!arstN)
            pcF <= '0;
        else if (!stall)
            pcF <= pcNextF;
    end

    assign imemIdx = imemWe ? imemAddr : pcF[IA+1:2];   // Load port owns it in reset

    wordMem #(.WORDS(IMEM_WORDS)) imem (
        .clk   (clk),
        .we    (imemWe),
        .addr  (imemIdx),
        .wdata (imemData),
        .rdata (instrF)
    );

    assign ifIdIn = '{instr: instrF, pcPlus4: pcPlus4F};

    pipeReg #(.payloadT(mipsPkg::ifIdT)) ifIdReg (
        .clk   (clk),
        .arstN (arstN),
        .en    (!stall),
        .flush (takenD),                          // Kill the slot behind a taken beq
        .d     (ifIdIn),
        .q     (ifIdOut)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign instrD = ifIdOut.instr;
    assign rsD    = instrD[25:21];
    assign rtD    = instrD[20:16];
    assign rdD    = instrD[15:11];
    assign immD   = {{(W-16){instrD[15]}}, instrD[15:0]};

    regFile regs (
        .clk   (clk),
        .arstN (arstN),
        .a1    (rsD),
        .a2    (rtD),
        .a3    (memWbOut.writeReg),
        .we    (memWbOut.regWrite),
        .wd    (resultW),
        .rd1   (rd1D),
        .rd2   (rd2D)
    );

    controlUnit ctrl (
        .op       (instrD[31:26]),
        .funct    (instrD[5:0]),
        .regWrite (regWriteD),
        .memToReg (memToRegD),
        .memWrite (memWriteD),
        .aluSrc   (aluSrcD),
        .regDst   (regDstD),
        .branch   (branchD),
        .aluOp    (aluOpD)
    );

    assign pcBranchD = ifIdOut.pcPlus4 + {immD[W-3:0], 2'b00};   // Word offset
    assign cmpAD     = forwardAD ? exMemOut.aluOut : rd1D;
    assign cmpBD     = forwardBD ? exMemOut.aluOut : rd2D;
    assign takenD    = branchD && (cmpAD == cmpBD) && !stall;    // Operands stale while stalled

    hazardUnit hazards (
        .rsD       (rsD),
        .rtD       (rtD),
        .rsE       (idExOut.rs),
        .rtE       (idExOut.rt),
        .writeRegE (writeRegE),
        .writeRegM (exMemOut.writeReg),
        .writeRegW (memWbOut.writeReg),
        .regWriteE (idExOut.regWrite),
        .regWriteM (exMemOut.regWrite),
        .regWriteW (memWbOut.regWrite),
        .memToRegE (idExOut.memToReg),
        .memToRegM (exMemOut.memToReg),
        .branchD   (branchD),
        .stall     (stall),
        .flushE    (flushE),
        .forwardAD (forwardAD),
        .forwardBD (forwardBD),
        .forwardAE (forwardAE),
        .forwardBE (forwardBE)
    );

    assign idExIn = '{
        regWrite: regWriteD,
        memToReg: memToRegD,
        memWrite: memWriteD,
        aluSrc:   aluSrcD,
        regDst:   regDstD,
        aluOp:    aluOpD,
        rd1:      rd1D,
        rd2:      rd2D,
        imm:      immD,
        rs:       rsD,
        rt:       rtD,
        rd:       rdD
    };

    pipeReg #(.payloadT(mipsPkg::idExT)) idExReg (
        .clk   (clk),
        .arstN (arstN),
        .en    (1'b1),
        .flush (flushE),                          // Bubble on stall
        .d     (idExIn),
        .q     (idExOut)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        case (forwardAE)
            mipsPkg::FWD_WB:  srcAE = resultW;
            mipsPkg::FWD_MEM: srcAE = exMemOut.aluOut;
            default:          srcAE = idExOut.rd1;
        endcase
        case (forwardBE)
            mipsPkg::FWD_WB:  writeDataE = resultW;
            mipsPkg::FWD_MEM: writeDataE = exMemOut.aluOut;
            default:          writeDataE = idExOut.rd2;
        endcase
    end

    assign srcBE     = idExOut.aluSrc ? idExOut.imm : writeDataE;
    assign writeRegE = idExOut.regDst ? idExOut.rd : idExOut.rt;

    always_comb
    begin
        case (idExOut.aluOp)
            mipsPkg::ALU_SUB: aluOutE = srcAE - srcBE;
            mipsPkg::ALU_AND: aluOutE = srcAE & srcBE;
            mipsPkg::ALU_OR:  aluOutE = srcAE | srcBE;
            mipsPkg::ALU_SLT: aluOutE = {{(W-1){1'b0}}, $signed(srcAE) < $signed(srcBE)};
            default:          aluOutE = srcAE + srcBE;   // add, addi, lw, sw
        endcase
    end

    assign exMemIn = '{
        regWrite:  idExOut.regWrite,
        memToReg:  idExOut.memToReg,
        memWrite:  idExOut.memWrite,
        aluOut:    aluOutE,
        writeData: writeDataE,
        writeReg:  writeRegE
    };

    pipeReg #(.payloadT(mipsPkg::exMemT)) exMemReg (
        .clk   (clk),
        .arstN (arstN),
        .en    (1'b1),
        .flush (1'b0),
        .d     (exMemIn),
        .q     (exMemOut)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Memory and writeback
    ////////////////////////////////////////////////////////////////////////////

    assign dmemIdx = exMemOut.aluOut[DA+1:2];     // Wraps modulo DMEM_WORDS

    wordMem #(.WORDS(DMEM_WORDS)) dmem (
        .clk   (clk),
        .we    (exMemOut.memWrite),
        .addr  (dmemIdx),
        .wdata (exMemOut.writeData),
        .rdata (readDataM)
    );

    assign memWbIn = '{
        regWrite: exMemOut.regWrite,
        memToReg: exMemOut.memToReg,
        readData: readDataM,
        aluOut:   exMemOut.aluOut,
        writeReg: exMemOut.writeReg
    };

    pipeReg #(.payloadT(mipsPkg::memWbT)) memWbReg (
        .clk   (clk),
        .arstN (arstN),
        .en    (1'b1),
        .flush (1'b0),
        .d     (memWbIn),
        .q     (memWbOut)
    );

    assign resultW = memWbOut.memToReg ? memWbOut.readData : memWbOut.aluOut;

    // Observation ports
    assign wbValid = memWbOut.regWrite && (memWbOut.writeReg != '0);   // r0 writes hidden
    assign wbReg   = memWbOut.writeReg;
    assign wbData  = resultW;
    assign stValid = exMemOut.memWrite;           // Same cycle as the RAM write
    assign stAddr  = dmemIdx;
    assign stData  = exMemOut.writeData;

endmodule

//--- dv/clkGen.sv
`timescale 1ns/1ps

module clkGen #(
    parameter int RESET_CYCLES = 2                // Rising edges with arstN low
) (
    output logic clk,
    output logic arstN
);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                    // 4 ns period
    end

    initial
    begin
        arstN = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        arstN <= 1'b1;                            // Release on an edge
    end

endmodule

//--- dv/tbModel.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

logic [mipsPkg::DATA_W-1:0] prog [PROG_LEN];     // Program image, halt in the last slot

// Expected events in program order
logic [mipsPkg::REG_AW-1:0] expWbReg  [$];
logic [mipsPkg::DATA_W-1:0] expWbData [$];
logic [DIDX_W-1:0]          expStAddr [$];
logic [mipsPkg::DATA_W-1:0] expStData [$];

function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

function automatic logic [4:0] pickReg(input logic [7:0] r);
    return 5'(r % 8'd7 + 8'd1);                   // r1..r7 only, lots of hazards
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

////////////////////////////////////////////////////////////////////////////
// Random program
////////////////////////////////////////////////////////////////////////////

task automatic buildProgram();
    logic [31:0] seed, ra, rb;
    logic [4:0]  rs, rt, rd;
    logic [5:0]  fn;
    int          kind, room, off;
    seed = 32'd45;
    for (int i = 0; i < PROG_LEN - 1; i++)
    begin
        ra   = xorshift(seed);
        rb   = xorshift(ra);
        seed = rb;
        kind = int'(ra % 32'd10);
        rs   = pickReg(ra[15:8]);
        rt   = pickReg(ra[23:16]);
        rd   = pickReg(ra[31:24]);
        room = PROG_LEN - 2 - i;                  // Furthest forward hop that still hits halt
        case (int'(rb % 32'd5))
            0:       fn = mipsPkg::FN_ADD;
            1:       fn = mipsPkg::FN_SUB;
            2:       fn = mipsPkg::FN_AND;
            3:       fn = mipsPkg::FN_OR;
            default: fn = mipsPkg::FN_SLT;
        endcase
        if (kind >= 8 && room < 1)
            kind = 4;                             // No room for a beq, use addi
        if (kind <= 3)
            prog[i] = {mipsPkg::OP_RTYPE, rs, rt, rd, 5'd0, fn};
        else if (kind <= 5)
            prog[i] = iWord(mipsPkg::OP_ADDI, rs, rt, rb[31:16]);
        else if (kind <= 7)
            prog[i] = iWord(kind == 6 ? mipsPkg::OP_LW : mipsPkg::OP_SW,
                            rb[4] ? 5'd0 : rs, rt, {10'd0, rb[9:6], 2'b00});
        else
        begin
            off = 1 + int'(rb % 32'd3);
            if (off > room)
                off = room;
            prog[i] = iWord(mipsPkg::OP_BEQ, rs, rb[5] ? rs : rt, 16'(off));   // Some always taken
        end
    end
    prog[PROG_LEN-1] = HALT_WORD;
endtask

////////////////////////////////////////////////////////////////////////////
// Sequential ISA model
////////////////////////////////////////////////////////////////////////////

task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] mem  [DMEM_WORDS];
    logic [31:0] ins, a, b, imm, res, addr;
    logic [4:0]  dst;
    logic        wr;
    int          pc;
    regs = '{default: '0};
    mem  = '{default: '0};
    pc   = 0;
    while (pc < PROG_LEN && prog[pc] != HALT_WORD)
    begin
        ins = prog[pc];
        a   = regs[ins[25:21]];
        b   = regs[ins[20:16]];
        imm = {{16{ins[15]}}, ins[15:0]};
        pc  = pc + 1;
        wr  = 1'b0;
        dst = ins[20:16];                         // rt unless R-type
        res = '0;
        addr = a + imm;
        case (ins[31:26])
            mipsPkg::OP_RTYPE:
            begin
                wr  = 1'b1;
                dst = ins[15:11];
                case (ins[5:0])
                    mipsPkg::FN_ADD: res = a + b;
                    mipsPkg::FN_SUB: res = a - b;
                    mipsPkg::FN_AND: res = a & b;
                    mipsPkg::FN_OR:  res = a | b;
                    mipsPkg::FN_SLT: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default:         wr = 1'b0;
                endcase
            end
            mipsPkg::OP_ADDI:
            begin
                wr  = 1'b1;
                res = addr;
            end
            mipsPkg::OP_LW:
            begin
                wr  = 1'b1;
                res = mem[addr[DIDX_W+1:2]];      // Index wraps with the memory size
            end
            mipsPkg::OP_SW:
            begin
                mem[addr[DIDX_W+1:2]] = b;
                expStAddr.push_back(addr[DIDX_W+1:2]);
                expStData.push_back(b);
            end
            mipsPkg::OP_BEQ:
            begin
                if (a == b)
                    pc = pc + int'($signed(imm));   // Relative to pc + 4
            end
            default:
                wr = 1'b0;
        endcase
        if (wr && dst != 5'd0)
        begin
            regs[dst] = res;
            expWbReg.push_back(dst);
            expWbData.push_back(res);
        end
    end
endtask

`endif

//--- dv/tbTop.sv
`timescale 1ns/1ps

module tbTop;

    localparam int IMEM_WORDS    = 64;
    localparam int DMEM_WORDS    = 16;
    localparam int IIDX_W        = $clog2(IMEM_WORDS);
    localparam int DIDX_W        = $clog2(DMEM_WORDS);
    localparam int PROG_LEN      = 40;
    localparam int RESET_TIMEOUT = 200;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int QUIET_CYCLES  = 50;            // Window after halt with no events
    localparam logic [31:0] HALT_WORD = {mipsPkg::OP_BEQ, 5'd0, 5'd0, 16'hffff};   // beq r0,r0,-1

    logic                       clk;
    logic                       arstN;
    logic                       imemWe;
    logic [IIDX_W-1:0]          imemAddr;
    logic [mipsPkg::DATA_W-1:0] imemData;
    logic                       wbValid;
    logic [mipsPkg::REG_AW-1:0] wbReg;
    logic [mipsPkg::DATA_W-1:0] wbData;
    logic                       stValid;
    logic [DIDX_W-1:0]          stAddr;
    logic [mipsPkg::DATA_W-1:0] stData;

    `include "tbModel.svh"

    // Reset covers 2 cycles plus one load write per instruction
    clkGen #(.RESET_CYCLES(2 + PROG_LEN)) clocks (
        .clk   (clk),
        .arstN (arstN)
    );

    dataPath #(
        .IMEM_WORDS (IMEM_WORDS),
        .DMEM_WORDS (DMEM_WORDS)
    ) UUT (
        .clk      (clk),
        .arstN    (arstN),
        .imemWe   (imemWe),
        .imemAddr (imemAddr),
        .imemData (imemData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData),
        .stValid  (stValid),
        .stAddr   (stAddr),
        .stData   (stData)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkRetire(input logic [mipsPkg::REG_AW-1:0] expReg,
                               input logic [mipsPkg::DATA_W-1:0] expData);
        if (wbReg !== expReg)
            abortRun($sformatf("[ERROR] %0d ns wbReg expected %0d actual %0d",
                               $time, expReg, wbReg));
        else if (wbData !== expData)
            abortRun($sformatf("[ERROR] %0d ns wbData (r%0d) expected %08h actual %08h",
                               $time, expReg, expData, wbData));
    endtask

    task automatic checkStore(input logic [DIDX_W-1:0]          expAddr,
                              input logic [mipsPkg::DATA_W-1:0] expData);
        if (stAddr !== expAddr)
            abortRun($sformatf("[ERROR] %0d ns stAddr expected %0d actual %0d",
                               $time, expAddr, stAddr));
        else if (stData !== expData)
            abortRun($sformatf("[ERROR] %0d ns stData expected %08h actual %08h",
                               $time, expData, stData));
    endtask

    // Outputs settle after the rising edge, sample in the low phase
    always @(negedge clk)
    begin
        logic [mipsPkg::REG_AW-1:0] eReg;
        logic [mipsPkg::DATA_W-1:0] eData;
        logic [DIDX_W-1:0]          eAddr;
        if (arstN && wbValid)
        begin
            if (expWbReg.size() == 0)
                abortRun("A register write retired that the model never produced");
            else
            begin
                eReg  = expWbReg.pop_front();
                eData = expWbData.pop_front();
                checkRetire(eReg, eData);
            end
        end
        if (arstN && stValid)
        begin
            if (expStAddr.size() == 0)
                abortRun("A store appeared that the model never produced");
            else
            begin
                eAddr = expStAddr.pop_front();
                eData = expStData.pop_front();
                checkStore(eAddr, eData);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        int cyc;
        imemWe   <= 1'b0;
        imemAddr <= '0;
        imemData <= '0;
        buildProgram();
        runModel();
        $display("Model expects %0d retires and %0d stores", expWbReg.size(), expStAddr.size());
        for (int i = 0; i < PROG_LEN; i++)
        begin
            @(posedge clk);
            imemWe   <= 1'b1;                     // One word per edge during reset
            imemAddr <= IIDX_W'(i);
            imemData <= prog[i];
        end
        @(posedge clk);
        imemWe <= 1'b0;
        cyc = 0;
        while (!arstN && cyc < RESET_TIMEOUT)
        begin
            @(posedge clk);
            cyc++;
        end
        if (!arstN)
            abortRun("Reset was never released");
        cyc = 0;
        while ((expWbReg.size() != 0 || expStAddr.size() != 0) && cyc < DRAIN_TIMEOUT)
        begin
            @(posedge clk);
            cyc++;
        end
        if (expWbReg.size() != 0)
            abortRun($sformatf("Timed out with %0d register writes still expected",
                               expWbReg.size()));
        else if (expStAddr.size() != 0)
            abortRun($sformatf("Timed out with %0d stores still expected", expStAddr.size()));
        else
        begin
            repeat (QUIET_CYCLES) @(posedge clk); // Monitor flags any late event
            $display("=== PASS ===");
            $finish;
        end
    end

endmodule

//--- tb.f
+incdir+dv
rtl/mipsPkg.sv
rtl/pipeReg.sv
rtl/regFile.sv
rtl/controlUnit.sv
rtl/hazardUnit.sv
rtl/wordMem.sv
rtl/dataPath.sv
dv/clkGen.sv
dv/tbTop.sv

//--- Makefile
SRCS := $(wildcard rtl/*.sv dv/*.sv dv/*.svh)

.PHONY: run clean

run: obj_dir/VtbTop
	./obj_dir/VtbTop

obj_dir/VtbTop: tb.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f tb.f --top-module tbTop -Mdir obj_dir -o VtbTop

clean:
	rm -rf obj_dir
